/* include/fg_consts.svh */
// Build-time sizes, weight store layout and credit count, included by the package and RTL
`ifndef FG_CONSTS_SVH
`define FG_CONSTS_SVH

// Vector and matrix sizes
`define FG_X        4
`define FG_L        4

// Fixed point format, Q7.8
`define FG_WIDTH    16
`define FG_FRAC     8

// Weight store layout
`define FG_ADDR_W   6
`define FG_W_BASE   0
`define FG_U_BASE   16
`define FG_B_BASE   32
`define FG_XV_BASE  40
`define FG_HV_BASE  48

// Output stream credits
`define FG_CREDITS  2

`endif

/* rtl/fg_pkg.sv */
// Shared word types, bus structs and FSM state enums of the forget gate unit
`include "fg_consts.svh"

package fg_pkg;

  //////////////////////////////////////////////////
  // Data words
  //////////////////////////////////////////////////

  // Q7.8 value as held in the store
  typedef logic signed [`FG_WIDTH-1:0] word_t;

  // Wide accumulator for dot products
  typedef logic signed [31:0] acc_t;

  //////////////////////////////////////////////////
  // Buses
  //////////////////////////////////////////////////

  // Host write port, no handshake
  typedef struct packed {
    logic                  valid;
    logic [`FG_ADDR_W-1:0] addr;
    word_t                 data;
  } load_t;

  // Engine read request, held until granted
  typedef struct packed {
    logic                  valid;
    logic [`FG_ADDR_W-1:0] addr;
  } rd_req_t;

  // Read return, one cycle after grant
  typedef struct packed {
    logic  valid;
    word_t data;
  } rd_rsp_t;

  // Row job to both engines
  typedef struct packed {
    logic       valid;
    logic [1:0] row;
  } job_t;

  // Engine partial sum
  typedef struct packed {
    logic valid;
    acc_t value;
  } partial_t;

  // Output stream element
  typedef struct packed {
    logic       valid;
    logic [1:0] row;
    word_t      data;
  } fout_t;

  //////////////////////////////////////////////////
  // FSM states
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_ISSUE,
    SEQ_WAIT,
    SEQ_CREDIT_WAIT
  } seq_state_e;

  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_FETCH,
    ENG_BIAS,
    ENG_DONE
  } eng_state_e;

endpackage

/* rtl/weight_store.sv */
// Single-port weight store holding W, U, b, x and h, read data one cycle after the address
`include "fg_consts.svh"

module weight_store (
  input  logic                  CLK,
  input  logic                  we,
  input  logic [`FG_ADDR_W-1:0] addr,
  input  fg_pkg::word_t         wdata,
  output fg_pkg::word_t         rdata
);

  localparam int DEPTH = 1 << `FG_ADDR_W;

  // Storage array
  fg_pkg::word_t mem [0:DEPTH-1];

  // Write port
  always_ff @(posedge CLK) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // Registered read
  // Old word comes back on a same-address write
  always_ff @(posedge CLK) begin
    rdata <= mem[addr];
  end

endmodule

/* rtl/store_arbiter.sv */
// Shares the weight store between the host load port and the two dot-product engines
`include "fg_consts.svh"

module store_arbiter (
  input  logic              CLK,
  input  logic              RST,
  input  fg_pkg::load_t     load,
  input  fg_pkg::rd_req_t   req_in,
  input  fg_pkg::rd_req_t   req_rec,
  output fg_pkg::rd_rsp_t   rsp_in,
  output fg_pkg::rd_rsp_t   rsp_rec,
  output logic              gnt_in,
  output logic              gnt_rec
);

  localparam int AW = `FG_ADDR_W;

  // Round-robin pointer, high when the recurrent engine goes first
  logic rr_rec;

  // Which engine owns the read in flight
  logic pend_in;
  logic pend_rec;

  // Store side
  logic          st_we;
  logic [AW-1:0] st_addr;
  fg_pkg::word_t st_wdata;
  fg_pkg::word_t st_rdata;

  //////////////////////////////////////////////////
  // Grant
  //////////////////////////////////////////////////

  // Load beats both engines
  always_comb begin
    gnt_in  = 1'b0;
    gnt_rec = 1'b0;
    if (!load.valid) begin
      if (req_in.valid && (!req_rec.valid || !rr_rec)) begin
        gnt_in = 1'b1;
      end else if (req_rec.valid) begin
        gnt_rec = 1'b1;
      end
    end
  end

  // Store address from the winner
  always_comb begin
    st_we    = load.valid;
    st_wdata = load.data;
    if (load.valid) begin
      st_addr = load.addr;
    end else if (gnt_rec) begin
      st_addr = req_rec.addr;
    end else begin
      st_addr = req_in.addr;
    end
  end

  // Pointer flips toward the engine that lost
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rr_rec   <= 1'b0;
      pend_in  <= 1'b0;
      pend_rec <= 1'b0;
    end else begin
      pend_in  <= gnt_in;
      pend_rec <= gnt_rec;
      if (gnt_in) begin
        rr_rec <= 1'b1;
      end else if (gnt_rec) begin
        rr_rec <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Store and return steering
  //////////////////////////////////////////////////

  weight_store u_store (
    .CLK   (CLK),
    .we    (st_we),
    .addr  (st_addr),
    .wdata (st_wdata),
    .rdata (st_rdata)
  );

  // Same data to both, valid only to the owner
  assign rsp_in.valid  = pend_in;
  assign rsp_in.data   = st_rdata;
  assign rsp_rec.valid = pend_rec;
  assign rsp_rec.data  = st_rdata;

endmodule

/* rtl/dot_engine.sv */
// Dot-product engine, one matrix row times one vector from the store, bias added on request
`include "fg_consts.svh"

module dot_engine #(
  parameter int MAT_BASE   = 0,
  parameter int VEC_BASE   = 0,
  parameter int LEN        = 4,
  parameter int ROW_STRIDE = 4,
  parameter bit ADD_BIAS   = 1'b0
) (
  input  logic              CLK,
  input  logic              RST,
  input  fg_pkg::job_t      job,
  output fg_pkg::rd_req_t   req,
  input  logic              gnt,
  input  fg_pkg::rd_rsp_t   rsp,
  output fg_pkg::partial_t  result
);

  // Matrix and vector reads alternate
  localparam int NRD = 2 * LEN;
  localparam int CW  = $clog2(NRD + 1);
  localparam int AW  = `FG_ADDR_W;

  fg_pkg::eng_state_e state;

  // Reads granted and reads returned
  logic [CW-1:0] iss_cnt;
  logic [CW-1:0] ret_cnt;
  logic          bias_iss;

  // Job row and datapath
  logic [1:0]    row_q;
  fg_pkg::word_t mat_q;
  fg_pkg::acc_t  acc;
  fg_pkg::acc_t  prod;

  //////////////////////////////////////////////////
  // Read requests
  //////////////////////////////////////////////////

  // Even index reads matrix, odd reads vector
  always_comb begin
    req.valid = 1'b0;
    req.addr  = '0;
    if (state == fg_pkg::ENG_FETCH && iss_cnt < CW'(NRD)) begin
      req.valid = 1'b1;
      if (!iss_cnt[0]) begin
        req.addr = AW'(MAT_BASE + 32'(row_q) * ROW_STRIDE + 32'(iss_cnt >> 1));
      end else begin
        req.addr = AW'(VEC_BASE + 32'(iss_cnt >> 1));
      end
    end else if (state == fg_pkg::ENG_BIAS && !bias_iss) begin
      req.valid = 1'b1;
      req.addr  = AW'(`FG_B_BASE + 32'(row_q));
    end
  end

  // Q7.8 product back to Q7.8 scale
  assign prod = (fg_pkg::acc_t'(mat_q) * fg_pkg::acc_t'(rsp.data)) >>> `FG_FRAC;

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= fg_pkg::ENG_IDLE;
      iss_cnt  <= '0;
      ret_cnt  <= '0;
      bias_iss <= 1'b0;
    end else begin
      case (state)
        fg_pkg::ENG_IDLE: begin
          if (job.valid) begin
            iss_cnt  <= '0;
            ret_cnt  <= '0;
            bias_iss <= 1'b0;
            state    <= fg_pkg::ENG_FETCH;
          end
        end
        fg_pkg::ENG_FETCH: begin
          if (gnt) begin
            iss_cnt <= iss_cnt + 1'b1;
          end
          // Last vector word closes the loop
          if (rsp.valid) begin
            ret_cnt <= ret_cnt + 1'b1;
            if (ret_cnt == CW'(NRD - 1)) begin
              state <= ADD_BIAS ? fg_pkg::ENG_BIAS : fg_pkg::ENG_DONE;
            end
          end
        end
        fg_pkg::ENG_BIAS: begin
          if (gnt) begin
            bias_iss <= 1'b1;
          end
          if (rsp.valid) begin
            state <= fg_pkg::ENG_DONE;
          end
        end
        default: begin
          state <= fg_pkg::ENG_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (state == fg_pkg::ENG_IDLE && job.valid) begin
      row_q <= job.row;
      acc   <= '0;
    end else if (state == fg_pkg::ENG_FETCH && rsp.valid) begin
      // Keep matrix word, multiply on the vector word
      if (!ret_cnt[0]) begin
        mat_q <= rsp.data;
      end else begin
        acc <= acc + prod;
      end
    end else if (state == fg_pkg::ENG_BIAS && rsp.valid) begin
      acc <= acc + fg_pkg::acc_t'(rsp.data);
    end
  end

  // One-cycle result
  assign result.valid = (state == fg_pkg::ENG_DONE);
  assign result.value = acc;

endmodule

/* rtl/gate_sequencer.sv */
// Row sequencer, issues one job per row to both engines once an output credit is free
`include "fg_consts.svh"

module gate_sequencer (
  input  logic          CLK,
  input  logic          RST,
  input  logic          start,
  input  logic          credit_ok,
  input  logic          done_in,
  input  logic          done_rec,
  output fg_pkg::job_t  job,
  output logic          busy
);

  fg_pkg::seq_state_e state;
  logic [1:0]         row_q;

  // Partials seen for the current row
  logic got_in;
  logic got_rec;
  logic both_done;

  // Both engines finished, counting this cycle's pulses
  assign both_done = (got_in | done_in) & (got_rec | done_rec);

  //////////////////////////////////////////////////
  // Row FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= fg_pkg::SEQ_IDLE;
      row_q   <= '0;
      got_in  <= 1'b0;
      got_rec <= 1'b0;
      busy    <= 1'b0;
    end else begin
      case (state)
        fg_pkg::SEQ_IDLE: begin
          // Busy still high one cycle after the last row
          // so a start here is dropped
          busy <= start & ~busy;
          if (start && !busy) begin
            row_q <= '0;
            state <= fg_pkg::SEQ_CREDIT_WAIT;
          end
        end
        fg_pkg::SEQ_CREDIT_WAIT: begin
          if (credit_ok) begin
            state <= fg_pkg::SEQ_ISSUE;
          end
        end
        fg_pkg::SEQ_ISSUE: begin
          got_in  <= 1'b0;
          got_rec <= 1'b0;
          state   <= fg_pkg::SEQ_WAIT;
        end
        fg_pkg::SEQ_WAIT: begin
          if (done_in) begin
            got_in <= 1'b1;
          end
          if (done_rec) begin
            got_rec <= 1'b1;
          end
          if (both_done) begin
            got_in  <= 1'b0;
            got_rec <= 1'b0;
            if (row_q == 2'(`FG_L - 1)) begin
              state <= fg_pkg::SEQ_IDLE;
            end else begin
              row_q <= row_q + 1'b1;
              state <= fg_pkg::SEQ_CREDIT_WAIT;
            end
          end
        end
        default: begin
          state <= fg_pkg::SEQ_IDLE;
        end
      endcase
    end
  end

  // Row stays on job.row for the activation stage
  assign job.valid = (state == fg_pkg::SEQ_ISSUE);
  assign job.row   = row_q;

endmodule

/* rtl/gate_activation.sv */
// Activation stage, adds both partials, applies the hard sigmoid and owns output credits
`include "fg_consts.svh"

module gate_activation (
  input  logic              CLK,
  input  logic              RST,
  input  fg_pkg::partial_t  part_in,
  input  fg_pkg::partial_t  part_rec,
  input  logic [1:0]        row,
  input  logic              credit_ret,
  output fg_pkg::fout_t     f_out,
  output logic              credit_ok
);

  localparam int CW = $clog2(`FG_CREDITS + 1);

  // 0.5 and 1.0 in Q7.8
  localparam fg_pkg::acc_t HALF = 1 <<< (`FG_FRAC - 1);
  localparam fg_pkg::acc_t ONE  = 1 <<< `FG_FRAC;

  // Partial holding registers
  logic         have_in;
  logic         have_rec;
  fg_pkg::acc_t held_in;
  fg_pkg::acc_t held_rec;

  // Operands, sum and activation
  fg_pkg::acc_t op_in;
  fg_pkg::acc_t op_rec;
  fg_pkg::acc_t sum;
  fg_pkg::acc_t hs;
  logic         fire;

  // Output register
  logic          out_valid;
  logic [1:0]    out_row;
  fg_pkg::word_t out_data;

  // Credit state
  logic [CW-1:0] credits;
  logic          in_flight;

  //////////////////////////////////////////////////
  // Combine and activate
  //////////////////////////////////////////////////

  // Partial arriving now bypasses its register
  assign op_in  = have_in  ? held_in  : part_in.value;
  assign op_rec = have_rec ? held_rec : part_rec.value;
  assign fire   = (have_in | part_in.valid) & (have_rec | part_rec.valid);
  assign sum    = op_in + op_rec;

  // s/4 + 0.5, clamped to 0 .. 1.0
  always_comb begin
    hs = (sum >>> 2) + HALF;
    if (hs < 0) begin
      hs = '0;
    end else if (hs > ONE) begin
      hs = ONE;
    end
  end

  //////////////////////////////////////////////////
  // Control and credits
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      have_in   <= 1'b0;
      have_rec  <= 1'b0;
      out_valid <= 1'b0;
      credits   <= CW'(`FG_CREDITS);
    end else begin
      out_valid <= fire;
      if (fire) begin
        have_in  <= 1'b0;
        have_rec <= 1'b0;
      end else begin
        if (part_in.valid) begin
          have_in <= 1'b1;
        end
        if (part_rec.valid) begin
          have_rec <= 1'b1;
        end
      end
      // Spend on emit, refund on return
      credits <= credits - CW'(fire) + CW'(credit_ret);
    end
  end

  // Payload registers
  always_ff @(posedge CLK) begin
    if (part_in.valid) begin
      held_in <= part_in.value;
    end
    if (part_rec.valid) begin
      held_rec <= part_rec.value;
    end
    if (fire) begin
      out_row  <= row;
      out_data <= fg_pkg::word_t'(hs);
    end
  end

  // Half-finished row keeps one credit for itself
  assign in_flight = have_in | have_rec;
  assign credit_ok = credits > CW'(in_flight);

  assign f_out.valid = out_valid;
  assign f_out.row   = out_row;
  assign f_out.data  = out_data;

endmodule

/* rtl/forget_gate_top.sv */
// Forget gate vector unit top, store, arbiter, two engines, sequencer and activation stage
`include "fg_consts.svh"

module forget_gate_top (
  input  logic           CLK,
  input  logic           RST,
  input  fg_pkg::load_t  load,
  input  logic           start,
  input  logic           credit_ret,
  output fg_pkg::fout_t  f_out,
  output logic           busy
);

  //////////////////////////////////////////////////
  // Interconnect
  //////////////////////////////////////////////////

  // Store access
  fg_pkg::rd_req_t  req_in;
  fg_pkg::rd_req_t  req_rec;
  fg_pkg::rd_rsp_t  rsp_in;
  fg_pkg::rd_rsp_t  rsp_rec;
  logic             gnt_in;
  logic             gnt_rec;

  // Jobs and results
  fg_pkg::job_t     job;
  fg_pkg::partial_t part_in;
  fg_pkg::partial_t part_rec;
  logic             credit_ok;

  store_arbiter u_arb (
    .CLK     (CLK),
    .RST     (RST),
    .load    (load),
    .req_in  (req_in),
    .req_rec (req_rec),
    .rsp_in  (rsp_in),
    .rsp_rec (rsp_rec),
    .gnt_in  (gnt_in),
    .gnt_rec (gnt_rec)
  );

  // W times x plus b
  dot_engine #(
    .MAT_BASE   (`FG_W_BASE),
    .VEC_BASE   (`FG_XV_BASE),
    .LEN        (`FG_X),
    .ROW_STRIDE (`FG_X),
    .ADD_BIAS   (1'b1)
  ) u_eng_in (
    .CLK    (CLK),
    .RST    (RST),
    .job    (job),
    .req    (req_in),
    .gnt    (gnt_in),
    .rsp    (rsp_in),
    .result (part_in)
  );

  // U times h
  dot_engine #(
    .MAT_BASE   (`FG_U_BASE),
    .VEC_BASE   (`FG_HV_BASE),
    .LEN        (`FG_L),
    .ROW_STRIDE (`FG_L),
    .ADD_BIAS   (1'b0)
  ) u_eng_rec (
    .CLK    (CLK),
    .RST    (RST),
    .job    (job),
    .req    (req_rec),
    .gnt    (gnt_rec),
    .rsp    (rsp_rec),
    .result (part_rec)
  );

  gate_sequencer u_seq (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start),
    .credit_ok (credit_ok),
    .done_in   (part_in.valid),
    .done_rec  (part_rec.valid),
    .job       (job),
    .busy      (busy)
  );

  gate_activation u_act (
    .CLK        (CLK),
    .RST        (RST),
    .part_in    (part_in),
    .part_rec   (part_rec),
    .row        (job.row),
    .credit_ret (credit_ret),
    .f_out      (f_out),
    .credit_ok  (credit_ok)
  );

endmodule

/* testbench/fg_clock.sv */
// Testbench clock and power-on reset source, instantiated once by the testbench top
module fg_clock #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 16
) (
  output logic CLK,
  output logic RST
);

  // Free-running clock, starts low
  initial begin
    CLK = 1'b0;
    forever begin
      #(PERIOD / 2);
      CLK = ~CLK;
    end
  end

  // Reset held for a fixed count, released on a falling edge
  initial begin
    RST = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
  end

endmodule

/* testbench/fg_checker.sv */
// Concurrent assertions on store grants, read returns and output credits, bound into the DUT
`include "fg_consts.svh"

module fg_checker (
  input logic          CLK,
  input logic          RST,
  input logic          gnt_in,
  input logic          gnt_rec,
  input logic          rsp_in_valid,
  input logic          rsp_rec_valid,
  input fg_pkg::word_t rsp_in_data,
  input fg_pkg::word_t rsp_rec_data,
  // Store word at each engine's requested address
  input fg_pkg::word_t in_word,
  input fg_pkg::word_t rec_word,
  input logic [31:0]   credit_cnt,
  input logic          out_valid
);

  //////////////////////////////////////////////////
  // Store arbitration
  //////////////////////////////////////////////////

  // Never both engines in one cycle
  a_one_grant: assert property (@(posedge CLK) disable iff (RST) !(gnt_in && gnt_rec))
    else $error("store granted to both engines in one cycle");

  // Return one cycle after the grant, carrying the requested word
  a_rsp_in: assert property (@(posedge CLK) disable iff (RST)
    rsp_in_valid |-> $past(gnt_in) && rsp_in_data == $past(in_word))
    else $error("input engine response without a grant or with the wrong word");

  a_rsp_rec: assert property (@(posedge CLK) disable iff (RST)
    rsp_rec_valid |-> $past(gnt_rec) && rsp_rec_data == $past(rec_word))
    else $error("recurrent engine response without a grant or with the wrong word");

  //////////////////////////////////////////////////
  // Output credits
  //////////////////////////////////////////////////

  a_credit_max: assert property (@(posedge CLK) disable iff (RST)
    credit_cnt <= 32'(`FG_CREDITS))
    else $error("credit count above the credit limit");

  // Emit decision made with a credit in hand
  a_emit_credit: assert property (@(posedge CLK) disable iff (RST)
    out_valid |-> $past(credit_cnt) != 32'd0)
    else $error("output emitted with no credit left");

endmodule

/* testbench/fg_tb.sv */
// Testbench top for the forget gate unit, loads the store, runs six tests and reports the result
`include "fg_consts.svh"

module fg_tb;

  localparam int AW      = `FG_ADDR_W;
  localparam int DEPTH   = 1 << AW;
  localparam int SW      = 6;
  localparam int MAX_OUT = 1 << SW;
  localparam int NO_HOLD = 1_000_000;

  logic          CLK;
  logic          RST;
  fg_pkg::load_t load;
  logic          start;
  logic          credit_ret = 1'b0;
  fg_pkg::fout_t f_out;
  logic          busy;

  // Mirror of the weight store
  fg_pkg::word_t mem_img [0:DEPTH-1];

  // Expected stream, filled by the stimulus
  fg_pkg::word_t exp_data [0:MAX_OUT-1];
  logic [1:0]    exp_row  [0:MAX_OUT-1];
  int            exp_total;

  // Owned by the compare process
  int rx_count;
  int ret_count;
  int cmp_errors;

  // Owned by the stimulus
  int ret_allow;
  int seq_errors;
  int tests_run;
  int tests_failed;
  int seed;

  fg_clock #(.PERIOD(100), .RESET_CYCLES(16)) u_clk (.CLK(CLK), .RST(RST));

  forget_gate_top u_dut (
    .CLK        (CLK),
    .RST        (RST),
    .load       (load),
    .start      (start),
    .credit_ret (credit_ret),
    .f_out      (f_out),
    .busy       (busy)
  );

  // Grant and return rules in the arbiter
  bind store_arbiter fg_checker u_chk_arb (
    .CLK           (CLK),
    .RST           (RST),
    .gnt_in        (gnt_in),
    .gnt_rec       (gnt_rec),
    .rsp_in_valid  (rsp_in.valid),
    .rsp_rec_valid (rsp_rec.valid),
    .rsp_in_data   (rsp_in.data),
    .rsp_rec_data  (rsp_rec.data),
    .in_word       (u_store.mem[req_in.addr]),
    .rec_word      (u_store.mem[req_rec.addr]),
    .credit_cnt    (32'd0),
    .out_valid     (1'b0)
  );

  // Credit rules in the activation stage
  bind gate_activation fg_checker u_chk_act (
    .CLK           (CLK),
    .RST           (RST),
    .gnt_in        (1'b0),
    .gnt_rec       (1'b0),
    .rsp_in_valid  (1'b0),
    .rsp_rec_valid (1'b0),
    .rsp_in_data   ('0),
    .rsp_rec_data  ('0),
    .in_word       ('0),
    .rec_word      ('0),
    .credit_cnt    (32'(credits)),
    .out_valid     (f_out.valid)
  );

  //////////////////////////////////////////////////
  // Reference model and compare tasks
  //////////////////////////////////////////////////

  // f(l) = hard_sigmoid(W.x + U.h + b), each product rescaled by the fraction bits
  function automatic fg_pkg::word_t ref_gate(input int l);
    int s;
    int p;
    int hs;
    int k;
    s = 0;
    for (k = 0; k < `FG_X; k++) begin
      p = int'(mem_img[AW'(`FG_W_BASE + l * `FG_X + k)]) * int'(mem_img[AW'(`FG_XV_BASE + k)]);
      s = s + (p >>> `FG_FRAC);
    end
    for (k = 0; k < `FG_L; k++) begin
      p = int'(mem_img[AW'(`FG_U_BASE + l * `FG_L + k)]) * int'(mem_img[AW'(`FG_HV_BASE + k)]);
      s = s + (p >>> `FG_FRAC);
    end
    s  = s + int'(mem_img[AW'(`FG_B_BASE + l)]);
    // s/4 + 0.5 clamped to 0 .. 1.0
    hs = (s >>> 2) + 128;
    if (hs < 0) begin
      hs = 0;
    end else if (hs > 256) begin
      hs = 256;
    end
    return fg_pkg::word_t'(hs);
  endfunction

  task automatic check_word(input string name, input fg_pkg::word_t got,
                            input fg_pkg::word_t exp, output int bad);
    bad = 0;
    if (got !== exp) begin
      $display("Fail %s got 0x%h expected 0x%h", name, got, exp);
      bad = 1;
    end
  endtask

  task automatic check_row(input string name, input logic [1:0] got,
                           input logic [1:0] exp, output int bad);
    bad = 0;
    if (got !== exp) begin
      $display("Fail %s got 0x%h expected 0x%h", name, got, exp);
      bad = 1;
    end
  endtask

  task automatic check_flag(input string name, input logic got,
                            input logic exp, output int bad);
    bad = 0;
    if (got !== exp) begin
      $display("Fail %s got 0x%h expected 0x%h", name, got, exp);
      bad = 1;
    end
  endtask

  //////////////////////////////////////////////////
  // Compare process and credit return
  //////////////////////////////////////////////////

  always @(negedge CLK) begin : compare_outputs
    int bad;
    credit_ret = 1'b0;
    if (!RST && f_out.valid) begin
      if (rx_count >= exp_total) begin
        $display("Output for row %0d arrived with nothing expected", f_out.row);
        cmp_errors++;
      end else begin
        check_row("f_out.row", f_out.row, exp_row[SW'(rx_count)], bad);
        cmp_errors += bad;
        check_word("f_out.data", f_out.data, exp_data[SW'(rx_count)], bad);
        cmp_errors += bad;
      end
      rx_count++;
    end
    // Hand back spent credits unless the stimulus holds them
    if (ret_count < rx_count && ret_count < ret_allow) begin
      credit_ret = 1'b1;
      ret_count++;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // Value in +-2.0
  function automatic fg_pkg::word_t rand_word();
    return fg_pkg::word_t'($random(seed) % 512);
  endfunction

  // Used regions zero, the rest an address pattern
  task automatic clear_image();
    int a;
    for (a = 0; a < DEPTH; a++) begin
      if (a < `FG_HV_BASE + `FG_L) begin
        mem_img[AW'(a)] = '0;
      end else begin
        mem_img[AW'(a)] = fg_pkg::word_t'(32'hA5A5 ^ (a * 259));
      end
    end
  endtask

  task automatic randomize_image();
    int a;
    clear_image();
    for (a = 0; a < `FG_HV_BASE + `FG_L; a++) begin
      mem_img[AW'(a)] = rand_word();
    end
  endtask

  task automatic load_range(input int first, input int count);
    int a;
    for (a = first; a < first + count; a++) begin
      @(negedge CLK);
      load.valid = 1'b1;
      load.addr  = AW'(a);
      load.data  = mem_img[AW'(a)];
    end
    @(negedge CLK);
    load = '0;
  endtask

  task automatic push_expected(input int l, input fg_pkg::word_t value);
    exp_row[SW'(exp_total)]  = 2'(l);
    exp_data[SW'(exp_total)] = value;
    exp_total++;
  endtask

  task automatic expect_rows();
    int l;
    for (l = 0; l < `FG_L; l++) begin
      push_expected(l, ref_gate(l));
    end
  endtask

  task automatic pulse_start();
    @(negedge CLK);
    start = 1'b1;
    @(negedge CLK);
    start = 1'b0;
  endtask

  // Polled on the rising edge, count moves on the falling one
  task automatic wait_outputs(input int target, input int limit);
    int n;
    n = 0;
    while (rx_count < target && n < limit) begin
      @(posedge CLK);
      n++;
    end
    if (rx_count < target) begin
      $display("Timeout: %0d of %0d outputs arrived", rx_count, target);
      seq_errors++;
    end
  endtask

  task automatic wait_idle(input int limit);
    int n;
    n = 0;
    @(negedge CLK);
    while (busy && n < limit) begin
      @(negedge CLK);
      n++;
    end
    if (busy) begin
      $display("Timeout: busy stayed high after the last output");
      seq_errors++;
    end
  endtask

  task automatic run_rows();
    pulse_start();
    wait_outputs(exp_total, 1000);
    wait_idle(20);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    int errs;
    errs = cmp_errors + seq_errors - errs_before;
    tests_run++;
    if (errs == 0) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      $display("Test %0d %s: %0d errors", tests_run, name, errs);
      tests_failed++;
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int errs0;
    int a;
    int n;
    int base;
    int bad;
    bit leak;
    seed      = 32'h2fe4_2f52;
    load      = '0;
    start     = 1'b0;
    ret_allow = NO_HOLD;

    // Reset release
    n = 0;
    while (RST && n < 100) begin
      @(negedge CLK);
      n++;
    end
    if (RST) begin
      $display("Timeout: reset never released");
      seq_errors++;
    end
    check_flag("busy", busy, 1'b0, bad);
    seq_errors += bad;
    check_flag("f_out.valid", f_out.valid, 1'b0, bad);
    seq_errors += bad;

    // Identity W, x = (1, 0, -1, 2)
    errs0 = cmp_errors + seq_errors;
    clear_image();
    for (a = 0; a < `FG_L; a++) begin
      mem_img[AW'(`FG_W_BASE + a * `FG_X + a)] = 16'sh0100;
    end
    mem_img[AW'(`FG_XV_BASE + 0)] = 16'sh0100;
    mem_img[AW'(`FG_XV_BASE + 2)] = 16'shFF00;
    mem_img[AW'(`FG_XV_BASE + 3)] = 16'sh0200;
    load_range(0, DEPTH);
    expect_rows();
    run_rows();
    finish_test("fixed vectors", errs0);

    // Two random images, all terms in play
    errs0 = cmp_errors + seq_errors;
    for (n = 0; n < 2; n++) begin
      randomize_image();
      load_range(0, DEPTH);
      expect_rows();
      run_rows();
    end
    finish_test("random run", errs0);

    // Rows 0,1 far above, rows 2,3 far below
    errs0 = cmp_errors + seq_errors;
    clear_image();
    for (a = 0; a < `FG_L * `FG_X; a++) begin
      mem_img[AW'(`FG_W_BASE + a)] = (a < 2 * `FG_X) ? 16'sh7F00 : 16'sh8100;
    end
    for (a = 0; a < `FG_X; a++) begin
      mem_img[AW'(`FG_XV_BASE + a)] = 16'sh7F00;
    end
    load_range(0, DEPTH);
    push_expected(0, 16'sh0100);
    push_expected(1, 16'sh0100);
    push_expected(2, 16'sh0000);
    push_expected(3, 16'sh0000);
    run_rows();
    finish_test("saturation", errs0);

    // Hold every credit, then release
    errs0 = cmp_errors + seq_errors;
    randomize_image();
    load_range(0, DEPTH);
    expect_rows();
    base      = rx_count;
    ret_allow = rx_count;
    pulse_start();
    wait_outputs(base + `FG_CREDITS, 1000);
    leak = 1'b0;
    for (n = 0; n < 300; n++) begin
      @(posedge CLK);
      leak |= (rx_count > base + `FG_CREDITS);
    end
    if (leak) begin
      $display("Output arrived while all credits were held");
      seq_errors++;
    end
    ret_allow = NO_HOLD;
    wait_outputs(exp_total, 1000);
    wait_idle(20);
    finish_test("credit back-pressure", errs0);

    // Second start mid-run is dropped
    errs0 = cmp_errors + seq_errors;
    expect_rows();
    base = rx_count;
    pulse_start();
    wait_outputs(base + 1, 1000);
    @(negedge CLK);
    check_flag("busy", busy, 1'b1, bad);
    seq_errors += bad;
    start = 1'b1;
    @(negedge CLK);
    start = 1'b0;
    wait_outputs(exp_total, 1000);
    wait_idle(20);
    leak = 1'b0;
    for (n = 0; n < 100; n++) begin
      @(negedge CLK);
      leak |= busy | (rx_count != base + `FG_L);
    end
    if (leak) begin
      $display("Unit ran again after a start that came while busy");
      seq_errors++;
    end
    finish_test("start while busy", errs0);

    // New h only, restart at once
    errs0 = cmp_errors + seq_errors;
    for (a = 0; a < `FG_L; a++) begin
      mem_img[AW'(`FG_HV_BASE + a)] = rand_word();
    end
    load_range(`FG_HV_BASE, `FG_L);
    expect_rows();
    run_rows();
    finish_test("back-to-back runs", errs0);

    $display("Tests run %0d, tests failed %0d, outputs %0d of %0d, errors %0d",
             tests_run, tests_failed, rx_count, exp_total, cmp_errors + seq_errors);
    if (tests_failed == 0 && cmp_errors + seq_errors == 0 && rx_count == exp_total) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+include
rtl/fg_pkg.sv
rtl/weight_store.sv
rtl/store_arbiter.sv
rtl/dot_engine.sv
rtl/gate_sequencer.sv
rtl/gate_activation.sv
rtl/forget_gate_top.sv
testbench/fg_clock.sv
testbench/fg_checker.sv
testbench/fg_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fg_tb -f build.f -o fg_sim \
  && ./obj_dir/fg_sim | tee /dev/stderr | grep -x "sim passed" > /dev/null \
  && echo "run.sh: simulation PASS" \
  || { echo "run.sh: simulation FAIL"; exit 1; }
